// ==== source/gbc_io_config.svh ====
`ifndef GBC_IO_CONFIG_SVH
`define GBC_IO_CONFIG_SVH

// Bus widths
`define ADDR_W           16
`define DATA_W           8

// ========================================
// Memory map
// ========================================
`define WRAM_LO          16'hC000
`define WRAM_HI          16'hDFFF
`define WRAM_BANK_BYTES  4096
`define IO_LO            16'hFF00
`define IO_HI            16'hFF7F

// Register addresses
`define ADDR_SB          16'hFF01
`define ADDR_SC          16'hFF02
`define ADDR_DIV         16'hFF04
`define ADDR_TIMA        16'hFF05
`define ADDR_TMA         16'hFF06
`define ADDR_TAC         16'hFF07
`define ADDR_IF          16'hFF0F
`define ADDR_KEY1        16'hFF4D
`define ADDR_RP          16'hFF56
`define ADDR_SVBK        16'hFF70
`define ADDR_IE          16'hFFFF

// Reset values
`define RST_SC           8'h7C
`define RST_SB           8'h00
`define RST_KEY1         8'hFD
`define RST_RP           8'h3E
`define UNMAPPED_DATA    8'hFF

// Timer periods in cycles, TIMA rate picked by TAC[1:0]
`define DIV_PERIOD       256
`define TIMA_PERIOD_0    1024
`define TIMA_PERIOD_1    16
`define TIMA_PERIOD_2    64
`define TIMA_PERIOD_3    256

`endif

// ==== source/gbc_io_pkg.sv ====
`include "gbc_io_config.svh"

package gbc_io_pkg;

   // One CPU-side access, at most one strobe high
   typedef struct packed {
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
      logic               we;
      logic               re;
   } bus_req_t;

   // Same-cycle answer from a register block
   typedef struct packed {
      logic               hit;
      logic [`DATA_W-1:0] rdata;
   } io_rsp_t;

   typedef struct packed {
      logic               valid;
      logic [`DATA_W-1:0] rdata;
   } cpu_rsp_t;

   typedef struct packed {
      logic vblank;
      logic lcdstat;
      logic serial;
      logic joypad;
   } ext_irq_t;

   // Console order, vblank sits in bit 0
   typedef struct packed {
      logic joypad;
      logic serial;
      logic timer;
      logic lcdstat;
      logic vblank;
   } irq_vec_t;

endpackage

// ==== source/memory_router.sv ====
`timescale 1ns/1ps
`include "gbc_io_config.svh"

module memory_router
   import gbc_io_pkg::*;
(
   input  logic     clock_in,
   input  logic     synch_reset,
   input  bus_req_t cpu_req,
   output bus_req_t io_req,
   output bus_req_t wram_req,
   input  io_rsp_t  sb_rsp,
   input  io_rsp_t  timer_rsp,
   input  io_rsp_t  irq_rsp,
   input  io_rsp_t  wram_rsp,
   input  io_rsp_t  svbk_rsp,
   output cpu_rsp_t cpu_rsp
);

   logic               io_sel;
   logic               wram_sel;
   logic               io_hit;
   logic               io_hit_q;
   logic               rd_q;
   logic [`DATA_W-1:0] io_data;
   logic [`DATA_W-1:0] io_data_q;

   // ========================================
   // Region decode
   // ========================================
   assign io_sel   = ((cpu_req.addr >= `IO_LO) && (cpu_req.addr <= `IO_HI)) ||
                     (cpu_req.addr == `ADDR_IE);
   assign wram_sel = (cpu_req.addr >= `WRAM_LO) && (cpu_req.addr <= `WRAM_HI);

   always_comb begin
      io_req      = cpu_req;
      io_req.we   = cpu_req.we & io_sel;
      io_req.re   = cpu_req.re & io_sel;
      wram_req    = cpu_req;
      wram_req.we = cpu_req.we & wram_sel;
      wram_req.re = cpu_req.re & wram_sel;
   end

   // Merge the same-cycle I/O answers
   assign io_hit  = sb_rsp.hit | timer_rsp.hit | irq_rsp.hit | svbk_rsp.hit;
   assign io_data = ({`DATA_W{sb_rsp.hit}}    & sb_rsp.rdata)    |
                    ({`DATA_W{timer_rsp.hit}} & timer_rsp.rdata) |
                    ({`DATA_W{irq_rsp.hit}}   & irq_rsp.rdata)   |
                    ({`DATA_W{svbk_rsp.hit}}  & svbk_rsp.rdata);

   // Hold I/O data one cycle so it meets the WRAM data
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         rd_q     <= 1'b0;
         io_hit_q <= 1'b0;
      end else begin
         rd_q     <= cpu_req.re;
         io_hit_q <= io_hit;
      end
   end

   always_ff @(posedge clock_in) begin
      io_data_q <= io_data;
   end

   always_comb begin
      cpu_rsp.valid = rd_q;
      if (io_hit_q) begin
         cpu_rsp.rdata = io_data_q;
      end else if (wram_rsp.hit) begin
         cpu_rsp.rdata = wram_rsp.rdata;
      end else begin
         cpu_rsp.rdata = `UNMAPPED_DATA;
      end
   end

endmodule

// ==== source/working_memory_bank.sv ====
`timescale 1ns/1ps
`include "gbc_io_config.svh"

module working_memory_bank
   import gbc_io_pkg::*;
(
   input  logic     clock_in,
   input  logic     synch_reset,
   input  bus_req_t io_req,
   input  bus_req_t wram_req,
   output io_rsp_t  svbk_rsp,
   output io_rsp_t  wram_rsp
);

   localparam int OFFSET_W = $clog2(`WRAM_BANK_BYTES);
   localparam int DEPTH    = 8 * `WRAM_BANK_BYTES;

   logic [`DATA_W-1:0]    mem [0:DEPTH-1];
   logic [2:0]            svbk_q;
   logic [2:0]            bank;
   logic [OFFSET_W+2:0]   index;
   logic                  rd_hit_q;
   logic [`DATA_W-1:0]    rd_data_q;

   // ========================================
   // Bank select register
   // ========================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         svbk_q <= 3'd0;
      end else if (io_req.we && (io_req.addr == `ADDR_SVBK)) begin
         svbk_q <= io_req.wdata[2:0];
      end
   end

   assign svbk_rsp.hit   = io_req.re && (io_req.addr == `ADDR_SVBK);
   assign svbk_rsp.rdata = svbk_rsp.hit ? {5'b11111, svbk_q} : '0;

   // Lower half fixed to bank 0, SVBK of zero still means bank 1
   always_comb begin
      if (!wram_req.addr[OFFSET_W]) begin
         bank = 3'd0;
      end else if (svbk_q == 3'd0) begin
         bank = 3'd1;
      end else begin
         bank = svbk_q;
      end
   end

   assign index = {bank, wram_req.addr[OFFSET_W-1:0]};

   always_ff @(posedge clock_in) begin
      if (wram_req.we) begin
         mem[index] <= wram_req.wdata;
      end
      rd_data_q <= mem[index];
   end

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         rd_hit_q <= 1'b0;
      end else begin
         rd_hit_q <= wram_req.re;
      end
   end

   assign wram_rsp.hit   = rd_hit_q;
   assign wram_rsp.rdata = rd_data_q;

endmodule

// ==== source/io_register_file.sv ====
`timescale 1ns/1ps
`include "gbc_io_config.svh"

module io_register_file
   import gbc_io_pkg::*;
(
   input  logic     clock_in,
   input  logic     synch_reset,
   input  bus_req_t io_req,
   output io_rsp_t  sb_rsp
);

   logic [`DATA_W-1:0] sb_q;
   logic [`DATA_W-1:0] sc_q;
   logic [`DATA_W-1:0] key1_q;
   logic [`DATA_W-1:0] rp_q;

   // Plain storage, serial and IR logic not modelled
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         sb_q   <= `RST_SB;
         sc_q   <= `RST_SC;
         key1_q <= `RST_KEY1;
         rp_q   <= `RST_RP;
      end else if (io_req.we) begin
         case (io_req.addr)
            `ADDR_SB:   sb_q   <= io_req.wdata;
            `ADDR_SC:   sc_q   <= io_req.wdata;
            `ADDR_KEY1: key1_q <= io_req.wdata;
            `ADDR_RP:   rp_q   <= io_req.wdata;
            default: ;
         endcase
      end
   end

   // Read mux
   always_comb begin
      sb_rsp.hit   = io_req.re;
      sb_rsp.rdata = '0;
      case (io_req.addr)
         `ADDR_SB:   sb_rsp.rdata = sb_q;
         `ADDR_SC:   sb_rsp.rdata = sc_q;
         `ADDR_KEY1: sb_rsp.rdata = key1_q;
         `ADDR_RP:   sb_rsp.rdata = rp_q;
         default:    sb_rsp.hit   = 1'b0;
      endcase
      if (!sb_rsp.hit) begin
         sb_rsp.rdata = '0;
      end
   end

endmodule

// ==== source/timer_unit.sv ====
`timescale 1ns/1ps
`include "gbc_io_config.svh"

module timer_unit
   import gbc_io_pkg::*;
(
   input  logic     clock_in,
   input  logic     synch_reset,
   input  bus_req_t io_req,
   output io_rsp_t  timer_rsp,
   output logic     timer_irq
);

   localparam int DIV_PRE_W = $clog2(`DIV_PERIOD);
   localparam logic [DIV_PRE_W-1:0] DIV_PRE_MAX = DIV_PRE_W'(`DIV_PERIOD - 1);

   logic [DIV_PRE_W-1:0] div_pre;
   logic [9:0]           tima_pre;
   logic [9:0]           tima_pre_max;
   logic [`DATA_W-1:0]   div_q;
   logic [`DATA_W-1:0]   tima_q;
   logic [`DATA_W-1:0]   tma_q;
   logic [2:0]           tac_q;
   logic                 div_wr;
   logic                 tima_wr;
   logic                 tma_wr;
   logic                 tac_wr;
   logic                 tima_tick;

   assign div_wr  = io_req.we && (io_req.addr == `ADDR_DIV);
   assign tima_wr = io_req.we && (io_req.addr == `ADDR_TIMA);
   assign tma_wr  = io_req.we && (io_req.addr == `ADDR_TMA);
   assign tac_wr  = io_req.we && (io_req.addr == `ADDR_TAC);

   // Rate select from TAC[1:0]
   always_comb begin
      case (tac_q[1:0])
         2'd0:    tima_pre_max = 10'(`TIMA_PERIOD_0 - 1);
         2'd1:    tima_pre_max = 10'(`TIMA_PERIOD_1 - 1);
         2'd2:    tima_pre_max = 10'(`TIMA_PERIOD_2 - 1);
         default: tima_pre_max = 10'(`TIMA_PERIOD_3 - 1);
      endcase
   end

   assign tima_tick = tac_q[2] && (tima_pre == tima_pre_max);

   // ========================================
   // Counters
   // ========================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         div_pre   <= '0;
         div_q     <= '0;
         tima_pre  <= '0;
         tima_q    <= '0;
         tma_q     <= '0;
         tac_q     <= '0;
         timer_irq <= 1'b0;
      end else begin
         timer_irq <= 1'b0;
         if (div_wr) begin
            div_pre <= '0;
            div_q   <= '0;
         end else if (div_pre == DIV_PRE_MAX) begin
            div_pre <= '0;
            div_q   <= div_q + 1'b1;
         end else begin
            div_pre <= div_pre + 1'b1;
         end
         // Prescaler idles at zero while the timer is stopped
         if (tac_wr || !tac_q[2] || tima_tick) begin
            tima_pre <= '0;
         end else begin
            tima_pre <= tima_pre + 1'b1;
         end
         if (tima_wr) begin
            tima_q <= io_req.wdata;
         end else if (tima_tick) begin
            if (tima_q == 8'hFF) begin
               tima_q    <= tma_q;
               timer_irq <= 1'b1;
            end else begin
               tima_q <= tima_q + 1'b1;
            end
         end
         if (tma_wr) begin
            tma_q <= io_req.wdata;
         end
         if (tac_wr) begin
            tac_q <= io_req.wdata[2:0];
         end
      end
   end

   always_comb begin
      timer_rsp.hit   = io_req.re;
      timer_rsp.rdata = '0;
      case (io_req.addr)
         `ADDR_DIV:  timer_rsp.rdata = div_q;
         `ADDR_TIMA: timer_rsp.rdata = tima_q;
         `ADDR_TMA:  timer_rsp.rdata = tma_q;
         `ADDR_TAC:  timer_rsp.rdata = {5'b11111, tac_q};
         default:    timer_rsp.hit   = 1'b0;
      endcase
      if (!timer_rsp.hit) begin
         timer_rsp.rdata = '0;
      end
   end

endmodule

// ==== source/interrupt_controller.sv ====
`timescale 1ns/1ps
`include "gbc_io_config.svh"

module interrupt_controller
   import gbc_io_pkg::*;
(
   input  logic     clock_in,
   input  logic     synch_reset,
   input  bus_req_t io_req,
   input  ext_irq_t ext_irq,
   input  logic     timer_irq,
   output io_rsp_t  irq_rsp,
   output irq_vec_t irq_pending
);

   irq_vec_t   req;
   logic [4:0] if_q;
   logic [4:0] ie_q;
   logic [4:0] if_next;
   logic [4:0] ie_next;

   // Gather request pulses in console bit order
   always_comb begin
      req.vblank  = ext_irq.vblank;
      req.lcdstat = ext_irq.lcdstat;
      req.timer   = timer_irq;
      req.serial  = ext_irq.serial;
      req.joypad  = ext_irq.joypad;
   end

   // Bus write lands first, new requests are ORed on top
   assign if_next = ((io_req.we && (io_req.addr == `ADDR_IF)) ? io_req.wdata[4:0] : if_q) | req;
   assign ie_next = (io_req.we && (io_req.addr == `ADDR_IE)) ? io_req.wdata[4:0] : ie_q;

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         if_q        <= '0;
         ie_q        <= '0;
         irq_pending <= '0;
      end else begin
         if_q        <= if_next;
         ie_q        <= ie_next;
         // Pending tracks the new flags on the same edge
         irq_pending <= irq_vec_t'(if_next & ie_next);
      end
   end

   always_comb begin
      irq_rsp.hit   = io_req.re && ((io_req.addr == `ADDR_IF) || (io_req.addr == `ADDR_IE));
      irq_rsp.rdata = '0;
      if (irq_rsp.hit) begin
         irq_rsp.rdata = (io_req.addr == `ADDR_IF) ? {3'b111, if_q} : {3'b111, ie_q};
      end
   end

endmodule

// ==== source/gbc_io_subsystem.sv ====
`timescale 1ns/1ps

module gbc_io_subsystem
   import gbc_io_pkg::*;
(
   input  logic     clock_in,
   input  logic     synch_reset,
   input  bus_req_t cpu_req,
   input  ext_irq_t ext_irq,
   output cpu_rsp_t cpu_rsp,
   output irq_vec_t irq_pending
);

   bus_req_t io_req;
   bus_req_t wram_req;
   io_rsp_t  sb_rsp;
   io_rsp_t  timer_rsp;
   io_rsp_t  irq_rsp;
   io_rsp_t  wram_rsp;
   io_rsp_t  svbk_rsp;
   logic     timer_irq;

   // ========================================
   // Bus fabric
   // ========================================
   memory_router router_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .cpu_req     (cpu_req),
      .io_req      (io_req),
      .wram_req    (wram_req),
      .sb_rsp      (sb_rsp),
      .timer_rsp   (timer_rsp),
      .irq_rsp     (irq_rsp),
      .wram_rsp    (wram_rsp),
      .svbk_rsp    (svbk_rsp),
      .cpu_rsp     (cpu_rsp)
   );

   working_memory_bank wram_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_req      (io_req),
      .wram_req    (wram_req),
      .svbk_rsp    (svbk_rsp),
      .wram_rsp    (wram_rsp)
   );

   // ========================================
   // I/O page blocks
   // ========================================
   io_register_file regs_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_req      (io_req),
      .sb_rsp      (sb_rsp)
   );

   timer_unit timer_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_req      (io_req),
      .timer_rsp   (timer_rsp),
      .timer_irq   (timer_irq)
   );

   interrupt_controller intc_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_req      (io_req),
      .ext_irq     (ext_irq),
      .timer_irq   (timer_irq),
      .irq_rsp     (irq_rsp),
      .irq_pending (irq_pending)
   );

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`include "gbc_io_config.svh"

module tb_top
   import gbc_io_pkg::*;
();

   localparam int RESET_CYCLES  = 5;
   localparam int TEST_CYCLES   = 20 + 120 + 80 + 1300 + 120;
   localparam int TIMEOUT_LIMIT = RESET_CYCLES + TEST_CYCLES + 200;

   logic     clock_in;
   logic     synch_reset;
   bus_req_t cpu_req;
   ext_irq_t ext_irq;
   cpu_rsp_t cpu_rsp;
   irq_vec_t irq_pending;

   logic [15:0] lfsr_state;
   int          rsp_errors;
   int          irq_errors;
   int          cycle_count;
   logic        model_live;
   cpu_rsp_t    exp_rsp;

   // Reference state
   logic [`DATA_W-1:0] m_mem [0:8*`WRAM_BANK_BYTES-1];
   logic [2:0]         m_svbk;
   logic [`DATA_W-1:0] m_sb;
   logic [`DATA_W-1:0] m_sc;
   logic [`DATA_W-1:0] m_key1;
   logic [`DATA_W-1:0] m_rp;
   int                 m_div_cycles;
   int                 m_tima_elapsed;
   logic [`DATA_W-1:0] m_tima;
   logic [`DATA_W-1:0] m_tma;
   logic [2:0]         m_tac;
   logic               m_timer_pulse;
   logic [4:0]         m_if;
   logic [4:0]         m_ie;
   logic [4:0]         m_pending;

   gbc_io_subsystem dut_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .cpu_req     (cpu_req),
      .ext_irq     (ext_irq),
      .cpu_rsp     (cpu_rsp),
      .irq_pending (irq_pending)
   );

   always #20 clock_in = ~clock_in;

   // Galois LFSR stepped once per bit
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] bits;
      logic        lsb;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         lsb        = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
         end
         bits = {bits[14:0], lsb};
      end
      return bits;
   endfunction

   // ========================================
   // Reference model
   // ========================================
   function automatic void reset_model();
      m_svbk         = 3'd0;
      m_sb           = `RST_SB;
      m_sc           = `RST_SC;
      m_key1         = `RST_KEY1;
      m_rp           = `RST_RP;
      m_div_cycles   = 0;
      m_tima_elapsed = 0;
      m_tima         = '0;
      m_tma          = '0;
      m_tac          = '0;
      m_timer_pulse  = 1'b0;
      m_if           = '0;
      m_ie           = '0;
      m_pending      = '0;
   endfunction

   function automatic int tima_period(input logic [1:0] sel);
      int p;
      case (sel)
         2'd0:    p = `TIMA_PERIOD_0;
         2'd1:    p = `TIMA_PERIOD_1;
         2'd2:    p = `TIMA_PERIOD_2;
         default: p = `TIMA_PERIOD_3;
      endcase
      return p;
   endfunction

   // Lower 4 KiB is bank 0 and the upper half follows SVBK with zero as bank 1
   function automatic logic [14:0] wram_index(input logic [15:0] addr);
      logic [2:0] bank;
      if (!addr[12]) begin
         bank = 3'd0;
      end else if (m_svbk == 3'd0) begin
         bank = 3'd1;
      end else begin
         bank = m_svbk;
      end
      return {bank, addr[11:0]};
   endfunction

   function automatic logic [7:0] predict_read(input logic [15:0] addr);
      logic [7:0] val;
      case (addr)
         `ADDR_SB:   val = m_sb;
         `ADDR_SC:   val = m_sc;
         `ADDR_KEY1: val = m_key1;
         `ADDR_RP:   val = m_rp;
         `ADDR_SVBK: val = {5'h1F, m_svbk};
         `ADDR_DIV:  val = 8'(m_div_cycles >> 8);
         `ADDR_TIMA: val = m_tima;
         `ADDR_TMA:  val = m_tma;
         `ADDR_TAC:  val = {5'h1F, m_tac};
         `ADDR_IF:   val = {3'h7, m_if};
         `ADDR_IE:   val = {3'h7, m_ie};
         default: begin
            if ((addr >= `WRAM_LO) && (addr <= `WRAM_HI)) begin
               val = m_mem[wram_index(addr)];
            end else begin
               val = `UNMAPPED_DATA;
            end
         end
      endcase
      return val;
   endfunction

   // Predicted response and the state after one clock edge
   function automatic cpu_rsp_t advance_model(input bus_req_t req, input ext_irq_t ext);
      cpu_rsp_t   rsp;
      logic [4:0] irq_in;
      logic       wr;
      logic       tick;
      logic       ovf;
      rsp.valid = req.re;
      rsp.rdata = predict_read(req.addr);
      wr        = req.we;
      irq_in    = {ext.joypad, ext.serial, m_timer_pulse, ext.lcdstat, ext.vblank};
      // Flag write first and new requests on top
      if (wr && (req.addr == `ADDR_IF)) begin
         m_if = req.wdata[4:0];
      end
      m_if = m_if | irq_in;
      if (wr && (req.addr == `ADDR_IE)) begin
         m_ie = req.wdata[4:0];
      end
      m_pending = m_if & m_ie;
      if (wr && (req.addr == `ADDR_DIV)) begin
         m_div_cycles = 0;
      end else begin
         m_div_cycles++;
      end
      tick = m_tac[2] && ((m_tima_elapsed + 1) == tima_period(m_tac[1:0]));
      ovf  = 1'b0;
      if (wr && (req.addr == `ADDR_TIMA)) begin
         m_tima = req.wdata;
      end else if (tick) begin
         if (m_tima == 8'hFF) begin
            m_tima = m_tma;
            ovf    = 1'b1;
         end else begin
            m_tima = m_tima + 8'd1;
         end
      end
      if (!m_tac[2] || tick || (wr && (req.addr == `ADDR_TAC))) begin
         m_tima_elapsed = 0;
      end else begin
         m_tima_elapsed++;
      end
      m_timer_pulse = ovf;
      if (wr) begin
         case (req.addr)
            `ADDR_TMA:  m_tma  = req.wdata;
            `ADDR_TAC:  m_tac  = req.wdata[2:0];
            `ADDR_SB:   m_sb   = req.wdata;
            `ADDR_SC:   m_sc   = req.wdata;
            `ADDR_KEY1: m_key1 = req.wdata;
            `ADDR_RP:   m_rp   = req.wdata;
            default: begin
               if ((req.addr >= `WRAM_LO) && (req.addr <= `WRAM_HI)) begin
                  m_mem[wram_index(req.addr)] = req.wdata;
               end
            end
         endcase
         // Bank select updates last
         if (req.addr == `ADDR_SVBK) begin
            m_svbk = req.wdata[2:0];
         end
      end
      return rsp;
   endfunction

   // ========================================
   // Compare tasks and checker
   // ========================================
   task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp);
      if ((got.valid !== exp.valid) || (exp.valid && (got.rdata !== exp.rdata))) begin
         rsp_errors++;
         $display("Error: cpu_rsp got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   task automatic check_irq(input irq_vec_t got, input irq_vec_t exp);
      if (got !== exp) begin
         irq_errors++;
         $display("Error: irq_pending got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   // Outputs and inputs are settled on the falling edge
   always @(negedge clock_in) begin
      if (model_live) begin
         check_rsp(cpu_rsp, exp_rsp);
         check_irq(irq_pending, irq_vec_t'(m_pending));
      end
      if (synch_reset) begin
         reset_model();
         exp_rsp = '0;
      end else begin
         exp_rsp = advance_model(cpu_req, ext_irq);
      end
      model_live = 1'b1;
   end

   // CPU side driver
   task automatic write_access(input logic [15:0] addr, input logic [7:0] data);
      bus_req_t req;
      req       = '0;
      req.addr  = addr;
      req.wdata = data;
      req.we    = 1'b1;
      @(posedge clock_in);
      cpu_req <= req;
   endtask

   task automatic read_access(input logic [15:0] addr);
      bus_req_t req;
      req      = '0;
      req.addr = addr;
      req.re   = 1'b1;
      @(posedge clock_in);
      cpu_req <= req;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clock_in);
         cpu_req <= '0;
      end
   endtask

   task automatic pulse_ext(input ext_irq_t v);
      @(posedge clock_in);
      cpu_req <= '0;
      ext_irq <= v;
      @(posedge clock_in);
      ext_irq <= '0;
   endtask

   // ========================================
   // Tests
   // ========================================
   task automatic reset_value_test();
      read_access(`ADDR_SB);
      read_access(`ADDR_SC);
      read_access(`ADDR_KEY1);
      read_access(`ADDR_RP);
      read_access(`ADDR_SVBK);
      read_access(`ADDR_IF);
      read_access(`ADDR_IE);
      read_access(`ADDR_TAC);
      // Nothing claims these
      read_access(16'hFF03);
      read_access(16'hFF7F);
      read_access(16'hE000);
   endtask

   task automatic wram_bank_test();
      logic [11:0] offs [4];
      write_access(`ADDR_SVBK, 8'h00);
      for (int i = 0; i < 4; i++) begin
         offs[i] = 12'(take_bits(12));
         write_access({4'hC, offs[i]}, 8'(take_bits(8)));
      end
      // Every bank shares the same offsets
      for (int b = 0; b < 8; b++) begin
         write_access(`ADDR_SVBK, 8'(b));
         for (int i = 0; i < 4; i++) begin
            write_access({4'hD, offs[i]}, 8'(take_bits(8)));
         end
      end
      for (int b = 0; b < 8; b++) begin
         write_access(`ADDR_SVBK, 8'(b));
         for (int i = 0; i < 4; i++) begin
            read_access({4'hD, offs[i]});
         end
         read_access({4'hC, offs[b % 4]});
      end
   endtask

   task automatic plain_reg_test();
      for (int n = 0; n < 8; n++) begin
         write_access(`ADDR_SB, 8'(take_bits(8)));
         write_access(`ADDR_SC, 8'(take_bits(8)));
         write_access(`ADDR_KEY1, 8'(take_bits(8)));
         write_access(`ADDR_RP, 8'(take_bits(8)));
         read_access(`ADDR_SB);
         read_access(`ADDR_SC);
         read_access(`ADDR_KEY1);
         read_access(`ADDR_RP);
      end
   endtask

   task automatic timer_test();
      write_access(`ADDR_TAC, 8'h00);
      write_access(`ADDR_TMA, 8'(take_bits(8)));
      write_access(`ADDR_TIMA, 8'hF8);
      // Start at the 16 cycle rate so TIMA overflows within 128 cycles
      write_access(`ADDR_TAC, 8'h05);
      for (int i = 0; i < 16; i++) begin
         idle_cycles(8 + int'(take_bits(5)));
         read_access(`ADDR_TIMA);
      end
      read_access(`ADDR_TMA);
      read_access(`ADDR_TAC);
      write_access(`ADDR_TAC, 8'h00);
      write_access(`ADDR_DIV, 8'h5A);
      idle_cycles(300);
      read_access(`ADDR_DIV);
      idle_cycles(256);
      read_access(`ADDR_DIV);
   endtask

   task automatic interrupt_test();
      write_access(`ADDR_IF, 8'h00);
      // Joypad stays disabled
      write_access(`ADDR_IE, 8'h0F);
      for (int i = 0; i < 4; i++) begin
         pulse_ext(ext_irq_t'(4'b1000 >> i));
         idle_cycles(2);
         read_access(`ADDR_IF);
      end
      write_access(`ADDR_IF, 8'h00);
      idle_cycles(2);
      write_access(`ADDR_TIMA, 8'hFE);
      write_access(`ADDR_TAC, 8'h05);
      idle_cycles(40);
      read_access(`ADDR_IF);
      write_access(`ADDR_TAC, 8'h00);
      write_access(`ADDR_IF, 8'h00);
      write_access(`ADDR_IE, 8'h00);
      pulse_ext(ext_irq_t'(4'b1000));
      idle_cycles(2);
      read_access(`ADDR_IF);
      read_access(`ADDR_IE);
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_LIMIT) begin
         @(posedge clock_in);
         cycle_count++;
      end
      $display("Timeout: tests still running after %0d cycles", TIMEOUT_LIMIT);
      $display("Regression failed");
      $finish;
   end

   initial begin
      clock_in    = 1'b0;
      synch_reset = 1'b1;
      cpu_req     = '0;
      ext_irq     = '0;
      lfsr_state  = 16'd73;
      rsp_errors  = 0;
      irq_errors  = 0;
      model_live  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock_in);
      synch_reset <= 1'b0;
      reset_value_test();
      wram_bank_test();
      plain_reg_test();
      timer_test();
      interrupt_test();
      idle_cycles(4);
      $display("Checks done: %0d response errors, %0d interrupt errors",
               rsp_errors, irq_errors);
      if ((rsp_errors == 0) && (irq_errors == 0)) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+source
source/gbc_io_pkg.sv
source/memory_router.sv
source/working_memory_bank.sv
source/io_register_file.sv
source/timer_unit.sv
source/interrupt_controller.sv
source/gbc_io_subsystem.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_top \
   --Mdir obj_dir -o tb_top_sim

./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported errors, see sim.log"
   exit 1
fi
